//--- Makefile
# Verilator build and run of the FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_asym_fifo
FILELIST  ?= asym_fifo_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TB PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- asym_fifo_ctrl.sv
module asym_fifo_ctrl #(
   parameter int W_DATA_W = asym_fifo_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = asym_fifo_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = asym_fifo_pkg::DEF_ADDR_W,
   localparam int W_ADDR_W = ADDR_W - ((W_DATA_W > R_DATA_W) ?
      asym_fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W) : 0),
   localparam int R_ADDR_W = ADDR_W - ((R_DATA_W > W_DATA_W) ?
      asym_fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W) : 0)
) (
   input  logic                r_clk_i,
   input  logic                reset_i,
   input  logic                w_en_i,
   input  logic                r_en_i,
   output logic                ram_wr_en_o,
   output logic [W_ADDR_W-1:0] ram_wr_addr_o,
   output logic                ram_rd_en_o,
   output logic [R_ADDR_W-1:0] ram_rd_addr_o,
   output logic                w_full_o,
   output logic                r_empty_o,
   output logic [ADDR_W:0]     level_o,
   output logic                r_valid_o
);

   import asym_fifo_pkg::*;

   // the fill level counts narrow units
   localparam int UNIT_W = min_w(W_DATA_W, R_DATA_W);
   localparam int LVL_W  = ADDR_W + 1;

   localparam logic [LVL_W-1:0] DEPTH  = {1'b1, {ADDR_W{1'b0}}};
   localparam logic [LVL_W-1:0] W_STEP = LVL_W'(W_DATA_W / UNIT_W);
   localparam logic [LVL_W-1:0] R_STEP = LVL_W'(R_DATA_W / UNIT_W);

   logic [W_ADDR_W-1:0] w_ptr_q;
   logic [R_ADDR_W-1:0] r_ptr_q;
   logic [LVL_W-1:0]    level_q;
   logic [LVL_W-1:0]    level_next;
   logic                full_q;
   logic                empty_q;
   logic                valid_q;
   logic                wr_ok;
   logic                rd_ok;

   // strobes only count when the registered flags allow them
   assign wr_ok = w_en_i && !full_q;
   assign rd_ok = r_en_i && !empty_q;

   always_comb begin
      level_next = level_q;
      if (wr_ok) begin
         level_next = level_next + W_STEP;
      end
      if (rd_ok) begin
         level_next = level_next - R_STEP;
      end
   end

   always_ff @(posedge r_clk_i) begin
      if (reset_i) begin
         w_ptr_q <= '0;
         r_ptr_q <= '0;
         level_q <= '0;
         full_q  <= 1'b0;
         empty_q <= 1'b1;
         valid_q <= 1'b0;
      end else begin
         // pointers step one word of their own width and wrap
         if (wr_ok) begin
            w_ptr_q <= w_ptr_q + 1'b1;
         end
         if (rd_ok) begin
            r_ptr_q <= r_ptr_q + 1'b1;
         end
         level_q <= level_next;
         // flags follow the level after this edge
         full_q  <= (DEPTH - level_next) < W_STEP;
         empty_q <= level_next < R_STEP;
         // read data leaves the RAM register one cycle later
         valid_q <= rd_ok;
      end
   end

   assign ram_wr_en_o   = wr_ok;
   assign ram_wr_addr_o = w_ptr_q;
   assign ram_rd_en_o   = rd_ok;
   assign ram_rd_addr_o = r_ptr_q;

   assign w_full_o  = full_q;
   assign r_empty_o = empty_q;
   assign level_o   = level_q;
   assign r_valid_o = valid_q;

   a_level_in_range: assert property (
      @(posedge r_clk_i) disable iff (reset_i) level_q <= DEPTH
   ) else begin
      $error("asym_fifo_ctrl: level %0d exceeds depth %0d", level_q, DEPTH);
   end

   // a RAM write needs room for a whole write word
   a_no_write_when_full: assert property (
      @(posedge r_clk_i) disable iff (reset_i)
      ram_wr_en_o |-> (DEPTH - level_q) >= W_STEP
   ) else begin
      $error("asym_fifo_ctrl: RAM write issued with no room left at level %0d", level_q);
   end

endmodule

//--- asym_fifo_pkg.sv
package asym_fifo_pkg;

   // narrow write side, wide read side
   localparam int DEF_W_DATA_W = 8;
   localparam int DEF_R_DATA_W = 32;

   // address bits on the narrow side, 1024 entries
   localparam int DEF_ADDR_W = 10;

   function automatic int max_w(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic int min_w(input int a, input int b);
      return (a < b) ? a : b;
   endfunction

   // log2 of wide over narrow, 0 for equal widths
   // rounds up for a ratio that is not a power of two
   function automatic int ratio_log2(input int a, input int b);
      int ratio;
      ratio = max_w(a, b) / min_w(a, b);
      return $clog2(ratio);
   endfunction

endpackage

//--- asym_fifo_top.f
asym_fifo_pkg.sv
ram_t2p.sv
ram_t2p_asym.sv
asym_fifo_ctrl.sv
asym_fifo_top.sv
tb_asym_fifo.sv

//--- asym_fifo_top.sv
module asym_fifo_top #(
   parameter int W_DATA_W = asym_fifo_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = asym_fifo_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = asym_fifo_pkg::DEF_ADDR_W
) (
   input  logic                r_clk_i,
   input  logic                reset_i,
   // write side
   input  logic                w_en_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   // read side
   input  logic                r_en_i,
   output logic [R_DATA_W-1:0] r_data_o,
   output logic                r_valid_o,
   // status
   output logic                w_full_o,
   output logic                r_empty_o,
   output logic [ADDR_W:0]     level_o
);

   import asym_fifo_pkg::*;

   localparam int W_ADDR_W = ADDR_W - ((W_DATA_W > R_DATA_W) ?
      ratio_log2(W_DATA_W, R_DATA_W) : 0);
   localparam int R_ADDR_W = ADDR_W - ((R_DATA_W > W_DATA_W) ?
      ratio_log2(W_DATA_W, R_DATA_W) : 0);

   logic                ram_wr_en;
   logic [W_ADDR_W-1:0] ram_wr_addr;
   logic                ram_rd_en;
   logic [R_ADDR_W-1:0] ram_rd_addr;

   // pointers, level and flags
   asym_fifo_ctrl #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_ctrl (
      .r_clk_i       (r_clk_i),
      .reset_i       (reset_i),
      .w_en_i        (w_en_i),
      .r_en_i        (r_en_i),
      .ram_wr_en_o   (ram_wr_en),
      .ram_wr_addr_o (ram_wr_addr),
      .ram_rd_en_o   (ram_rd_en),
      .ram_rd_addr_o (ram_rd_addr),
      .w_full_o      (w_full_o),
      .r_empty_o     (r_empty_o),
      .level_o       (level_o),
      .r_valid_o     (r_valid_o)
   );

   // storage, narrow in and wide out
   ram_t2p_asym #(
      .W_DATA_W (W_DATA_W),
      .R_DATA_W (R_DATA_W),
      .ADDR_W   (ADDR_W)
   ) i_ram (
      .r_clk_i  (r_clk_i),
      .w_en_i   (ram_wr_en),
      .w_addr_i (ram_wr_addr),
      .w_data_i (w_data_i),
      .r_en_i   (ram_rd_en),
      .r_addr_i (ram_rd_addr),
      .r_data_o (r_data_o)
   );

endmodule

//--- ram_t2p.sv
module ram_t2p #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 10
) (
   input  logic              r_clk_i,
   input  logic              w_en_i,
   input  logic [ADDR_W-1:0] w_addr_i,
   input  logic [DATA_W-1:0] w_data_i,
   input  logic              r_en_i,
   input  logic [ADDR_W-1:0] r_addr_i,
   output logic [DATA_W-1:0] r_data_o
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   // write port
   always_ff @(posedge r_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // registered read, output holds while r_en_i is low
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= mem[r_addr_i];
      end
   end

   // an unknown address would corrupt an arbitrary entry
   a_waddr_known: assert property (
      @(posedge r_clk_i) w_en_i |-> !$isunknown(w_addr_i)
   ) else begin
      $error("ram_t2p: write address unknown while w_en_i is high");
   end

endmodule

//--- ram_t2p_asym.sv
module ram_t2p_asym #(
   parameter int W_DATA_W = asym_fifo_pkg::DEF_W_DATA_W,
   parameter int R_DATA_W = asym_fifo_pkg::DEF_R_DATA_W,
   parameter int ADDR_W   = asym_fifo_pkg::DEF_ADDR_W,
   // the wider side needs fewer address bits
   localparam int W_ADDR_W = ADDR_W - ((W_DATA_W > R_DATA_W) ?
      asym_fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W) : 0),
   localparam int R_ADDR_W = ADDR_W - ((R_DATA_W > W_DATA_W) ?
      asym_fifo_pkg::ratio_log2(W_DATA_W, R_DATA_W) : 0)
) (
   input  logic                r_clk_i,
   input  logic                w_en_i,
   input  logic [W_ADDR_W-1:0] w_addr_i,
   input  logic [W_DATA_W-1:0] w_data_i,
   input  logic                r_en_i,
   input  logic [R_ADDR_W-1:0] r_addr_i,
   output logic [R_DATA_W-1:0] r_data_o
);

   import asym_fifo_pkg::*;

   localparam int MAX_W       = max_w(W_DATA_W, R_DATA_W);
   localparam int MIN_W       = min_w(W_DATA_W, R_DATA_W);
   localparam int LSEL_W      = ratio_log2(W_DATA_W, R_DATA_W);
   localparam int LANES       = MAX_W / MIN_W;
   localparam int LANE_ADDR_W = ADDR_W - LSEL_W;

   // per-lane buses
   logic [LANES-1:0]       lane_wr_en;
   logic [LANE_ADDR_W-1:0] lane_wr_addr [LANES];
   logic [MIN_W-1:0]       lane_wr_data [LANES];
   logic [LANE_ADDR_W-1:0] lane_rd_addr [LANES];
   logic [MIN_W-1:0]       lane_rd_data [LANES];

   // one narrow symmetric RAM per lane
   for (genvar i = 0; i < LANES; i++) begin : g_lane
      ram_t2p #(
         .DATA_W (MIN_W),
         .ADDR_W (LANE_ADDR_W)
      ) i_ram (
         .r_clk_i  (r_clk_i),
         .w_en_i   (lane_wr_en[i]),
         .w_addr_i (lane_wr_addr[i]),
         .w_data_i (lane_wr_data[i]),
         .r_en_i   (r_en_i),
         .r_addr_i (lane_rd_addr[i]),
         .r_data_o (lane_rd_data[i])
      );
   end

   if (W_DATA_W > R_DATA_W) begin : g_wide_wr
      // low read address bits, aligned with the lane output register
      logic [LSEL_W-1:0] rd_sel_q;

      for (genvar i = 0; i < LANES; i++) begin : g_conn
         // write all lanes at once
         assign lane_wr_en[i]   = w_en_i;
         assign lane_wr_addr[i] = w_addr_i;
         assign lane_wr_data[i] = w_data_i[i*MIN_W +: MIN_W];
         // read one lane at a time
         assign lane_rd_addr[i] = r_addr_i[R_ADDR_W-1 -: LANE_ADDR_W];
      end

      always_ff @(posedge r_clk_i) begin
         if (r_en_i) begin
            rd_sel_q <= r_addr_i[LSEL_W-1:0];
         end
      end

      assign r_data_o = lane_rd_data[rd_sel_q];
   end else if (W_DATA_W < R_DATA_W) begin : g_wide_rd
      for (genvar i = 0; i < LANES; i++) begin : g_conn
         // low write address bits pick the lane, lane 0 holds the first word
         assign lane_wr_en[i]   = w_en_i && (w_addr_i[LSEL_W-1:0] == LSEL_W'(i));
         assign lane_wr_addr[i] = w_addr_i[W_ADDR_W-1 -: LANE_ADDR_W];
         assign lane_wr_data[i] = w_data_i;
         // all lanes side by side form the wide word
         assign lane_rd_addr[i] = r_addr_i;
         assign r_data_o[i*MIN_W +: MIN_W] = lane_rd_data[i];
      end
   end else begin : g_equal
      // single lane, straight through
      assign lane_wr_en[0]   = w_en_i;
      assign lane_wr_addr[0] = w_addr_i;
      assign lane_wr_data[0] = w_data_i;
      assign lane_rd_addr[0] = r_addr_i;
      assign r_data_o        = lane_rd_data[0];
   end

   // lane steering only works for a power-of-two width ratio
   a_ratio_pow2: assert property (
      @(posedge r_clk_i)
      (MAX_W % MIN_W == 0) && (LANES >= 1) && ((1 << LSEL_W) == LANES)
   ) else begin
      $error("ram_t2p_asym: width ratio %0d/%0d is not a power of two", MAX_W, MIN_W);
   end

endmodule

//--- tb_asym_fifo.sv
module tb_asym_fifo;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int W_W            = 8;
   localparam int R_W            = 32;
   localparam int LVL_W          = 11;
   localparam int DEPTH          = 1024;
   localparam int W_STEP         = 1;
   localparam int BYTES_PER_WORD = R_W / W_W;
   localparam int STREAM_CYCLES  = 2000;
   localparam int SEED           = 3158;
   // all tests together run for about 4000 cycles
   localparam int TEST_CYCLES    = 4000;
   localparam int TIMEOUT_CYCLES = 5 * TEST_CYCLES;

   logic             r_clk_i;
   logic             reset_i;
   logic             w_en_i;
   logic [W_W-1:0]   w_data_i;
   logic             r_en_i;
   logic [R_W-1:0]   r_data_o;
   logic             r_valid_o;
   logic             w_full_o;
   logic             r_empty_o;
   logic [LVL_W-1:0] level_o;

   // reference model, bytes in write order and words owed to the reader
   logic [W_W-1:0] byte_q [$];
   logic [R_W-1:0] word_q [$];
   bit             rd_expected = 1'b0;
   bit             valid_prev  = 1'b0;
   int             valid_count = 0;
   int             b2b_count   = 0;
   int             cycle_count = 0;

   asym_fifo_top i_dut (
      .r_clk_i   (r_clk_i),
      .reset_i   (reset_i),
      .w_en_i    (w_en_i),
      .w_data_i  (w_data_i),
      .r_en_i    (r_en_i),
      .r_data_o  (r_data_o),
      .r_valid_o (r_valid_o),
      .w_full_o  (w_full_o),
      .r_empty_o (r_empty_o),
      .level_o   (level_o)
   );

   initial begin
      r_clk_i = 1'b0;
      forever #4 r_clk_i = ~r_clk_i;
   end

   task automatic stop_with_failure();
      $display("TB FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
         stop_with_failure();
      end
   endtask

   task automatic check_true(input bit cond, input string what);
      assert (cond) else begin
         $display("ERROR: %s", what);
         stop_with_failure();
      end
   endtask

   // one clock of stimulus, flags checked against the model at the falling edge
   task automatic drive_cycle(input bit wr, input logic [W_W-1:0] data, input bit rd);
      bit             exp_full;
      bit             exp_empty;
      logic [R_W-1:0] word;
      @(posedge r_clk_i);
      w_en_i   <= wr;
      w_data_i <= data;
      r_en_i   <= rd;
      @(negedge r_clk_i);
      exp_full  = (DEPTH - byte_q.size()) < W_STEP;
      exp_empty = byte_q.size() < BYTES_PER_WORD;
      check_value("level_o", 32'(level_o), 32'(byte_q.size()));
      check_value("w_full_o", 32'(w_full_o), 32'(exp_full));
      check_value("r_empty_o", 32'(r_empty_o), 32'(exp_empty));
      check_value("r_valid_o", 32'(r_valid_o), 32'(rd_expected));
      // strobes just driven are taken at the next rising edge
      if (wr && !exp_full) begin
         byte_q.push_back(data);
      end
      rd_expected = rd && !exp_empty;
      if (rd_expected) begin
         // first byte in lands in the low lane
         for (int i = 0; i < BYTES_PER_WORD; i++) begin
            word[i*W_W +: W_W] = byte_q.pop_front();
         end
         word_q.push_back(word);
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) drive_cycle(1'b0, '0, 1'b0);
   endtask

   task automatic reset_state();
      int start_valid;
      start_valid = valid_count;
      idle(6);
      check_value("r_empty_o", 32'(r_empty_o), 32'h1);
      check_value("w_full_o", 32'(w_full_o), 32'h0);
      check_value("level_o", 32'(level_o), 32'h0);
      check_true(valid_count == start_valid, "r_valid_o pulsed after reset without a read");
   endtask

   task automatic byte_assembly();
      int start_valid;
      start_valid = valid_count;
      drive_cycle(1'b1, 8'h3c, 1'b0);
      drive_cycle(1'b1, 8'h5a, 1'b0);
      drive_cycle(1'b1, 8'h96, 1'b0);
      drive_cycle(1'b1, 8'he1, 1'b0);
      drive_cycle(1'b0, '0, 1'b1);
      idle(1);
      check_value("r_data_o", r_data_o, 32'he1965a3c);
      idle(1);
      check_value("level_o", 32'(level_o), 32'h0);
      check_true(valid_count == start_valid + 1, "expected exactly one word from four bytes");
   endtask

   task automatic fill_and_drain();
      int accepted;
      int guard;
      int start_size;
      int start_valid;
      guard      = 0;
      start_size = byte_q.size();
      while (w_full_o !== 1'b1 && guard < DEPTH + 16) begin
         drive_cycle(1'b1, 8'($urandom()), 1'b0);
         guard++;
      end
      accepted = byte_q.size() - start_size;
      check_true(w_full_o === 1'b1, "w_full_o never rose while filling");
      check_true(accepted == DEPTH,
                 $sformatf("filling took %0d writes instead of %0d", accepted, DEPTH));
      // this byte must never come out
      drive_cycle(1'b1, 8'hc3, 1'b0);
      idle(1);
      check_value("level_o", 32'(level_o), 32'(DEPTH));
      start_valid = valid_count;
      repeat (DEPTH / BYTES_PER_WORD) drive_cycle(1'b0, '0, 1'b1);
      idle(2);
      check_value("r_empty_o", 32'(r_empty_o), 32'h1);
      check_true(valid_count - start_valid == DEPTH / BYTES_PER_WORD,
                 "drain did not return one word per read");
      check_true(word_q.size() == 0, "words still owed after the drain");
   endtask

   task automatic empty_read_ignored();
      int start_valid;
      start_valid = valid_count;
      repeat (4) drive_cycle(1'b0, '0, 1'b1);
      idle(2);
      check_value("level_o", 32'(level_o), 32'h0);
      check_true(valid_count == start_valid, "a read from an empty FIFO produced data");
      repeat (BYTES_PER_WORD) drive_cycle(1'b1, 8'($urandom()), 1'b0);
      drive_cycle(1'b0, '0, 1'b1);
      idle(2);
      check_true(valid_count == start_valid + 1, "write then read did not return a word");
      check_true(word_q.size() == 0, "a word is still owed after write then read");
   endtask

   task automatic streaming();
      bit wr;
      bit rd;
      int start_valid;
      int start_b2b;
      start_valid = valid_count;
      start_b2b   = b2b_count;
      // some backlog first so reads can run on consecutive edges
      repeat (64) drive_cycle(1'b1, 8'($urandom()), 1'b0);
      for (int n = 0; n < STREAM_CYCLES; n++) begin
         wr = ($urandom() % 4) != 0;
         rd = !r_empty_o;
         drive_cycle(wr, 8'($urandom()), rd);
      end
      idle(3);
      check_true(word_q.size() == 0, "words still owed after streaming");
      check_true(valid_count > start_valid, "no words came out while streaming");
      check_true(b2b_count > start_b2b, "no back-to-back reads while streaming");
   endtask

   // data check on every valid word
   always @(negedge r_clk_i) begin
      if (!reset_i && r_valid_o === 1'b1) begin
         check_true(word_q.size() > 0, "r_valid_o pulsed with no read outstanding");
         check_value("r_data_o", r_data_o, word_q.pop_front());
         valid_count++;
         if (valid_prev) begin
            b2b_count++;
         end
      end
      valid_prev = (r_valid_o === 1'b1);
   end

   always @(posedge r_clk_i) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
         stop_with_failure();
      end
   end

   initial begin
      reset_i  = 1'b1;
      w_en_i   = 1'b0;
      w_data_i = '0;
      r_en_i   = 1'b0;
      void'($urandom(SEED));
      repeat (5) @(posedge r_clk_i);
      reset_i <= 1'b0;
      reset_state();
      byte_assembly();
      fill_and_drain();
      empty_read_ignored();
      streaming();
      $display("TB PASSED");
      $finish;
   end

endmodule
